//--- verif/uartTests.txt
# Columns: operation, test name, hex value (byte sent or received, divisor or address)
# Operations: reset, div, rx, ferr, glitch, ovr, tx, empty, unmapped
reset afterReset 0
rx rxDefaultA 55
rx rxDefaultB a3
glitch shortGlitch 0
ferr badStopBit 3c
rx afterBadStop 81
div setDivisor 0a
rx rxFastA 00
rx rxFastB ff
rx rxFastC 6e
glitch fastGlitch 0
ovr fifoOverrun 10
empty readEmpty 0
tx txByteA c5
tx txByteB 3a
unmapped badAddrC 0c
unmapped badAddrFc fc
div restoreDivisor 10
rx rxSlow 99
tx txSlow 5a

//--- files.f
+incdir+verilog
verilog/uartPkg.sv
verilog/uartByteIf.sv
verilog/baudTickGen.sv
verilog/uartRx.sv
verilog/uartTx.sv
verilog/rxFifo.sv
verilog/uartApbRegs.sv
verilog/uartTop.sv
verif/uartTb.sv

//--- Makefile
TOP = uartTb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/uartTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartDefs.svh"

module uartTb;
    localparam int modeClean   = 0;
    localparam int modeBadStop = 1;
    localparam int modeGlitch  = 2;

    logic        clk;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        rxd;
    logic        txd;

    int    curDiv;    // Clocks per oversample tick, tracks CTRL
    int    bitClks;
    string testName;

    uartTop u_dut (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .rxd     (rxd),
        .txd     (txd)
    );

    assign bitClks = `UART_OVERSAMPLE * curDiv;

    always #5 clk = ~clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            abortRun($sformatf("Fail %s %s: expected %0h, actual %0h",
                               testName, what, expected, actual));
    endtask

    // Leaves the caller 1 ns after a rising edge
    task automatic nextCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic apbAccess(input logic [7:0] addr, input logic write,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic [31:0] err);
        nextCycles(1);
        paddr  = addr;
        pwrite = write;
        pwdata = wdata;
        psel   = 1'b1;
        nextCycles(1);
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = {31'b0, pslverr};
        nextCycles(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] rdata,
                           output logic [31:0] err);
        apbAccess(addr, 1'b0, 32'h0, rdata, err);
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] err);
        logic [31:0] unused;
        apbAccess(addr, 1'b1, wdata, unused, err);
    endtask

    // Start bit, LSB first data, stop bit, then a random idle gap
    task automatic sendSerial(input logic [7:0] data, input int mode);
        logic [9:0] frame;
        int         i;
        frame = {mode != modeBadStop, data, 1'b0};
        nextCycles(1);
        if (mode == modeGlitch)
        begin
            rxd = 1'b0;
            nextCycles(2 * curDiv);    // A quarter of a bit
        end
        else
        begin
            for (i = 0; i < 10; i++)
            begin
                rxd = frame[i];
                nextCycles(bitClks);
            end
        end
        rxd = 1'b1;
        nextCycles(8 + $urandom % 40);
    endtask

    task automatic expectStatus(input logic [31:0] expected);
        logic [31:0] rdata;
        logic [31:0] err;
        apbRead(`UART_ADDR_STATUS, rdata, err);
        check("status", expected, rdata);
        check("status error", 0, err);
    endtask

    task automatic waitRxValid();
        logic [31:0] rdata;
        logic [31:0] err;
        int          polls;
        polls = 0;
        rdata = '0;
        while (rdata[0] !== 1'b1)
        begin
            if (polls > 8 * curDiv + 100)
                abortRun("Timeout waiting for a received byte in STATUS");
            else
            begin
                apbRead(`UART_ADDR_STATUS, rdata, err);
                polls++;
            end
        end
    endtask

    task automatic readData(input logic [7:0] expected);
        logic [31:0] rdata;
        logic [31:0] err;
        apbRead(`UART_ADDR_DATA, rdata, err);
        check("data", {24'h0, expected}, rdata);
        check("data error", 0, err);
    endtask

    task automatic captureTx(output logic [7:0] data);
        int waits;
        int i;
        waits = 0;
        data  = '0;
        while (txd !== 1'b0)
        begin
            if (waits > 2 * bitClks + 50)
                abortRun("Timeout waiting for a start bit on txd");
            else
            begin
                @(negedge clk);
                waits++;
            end
        end
        repeat (bitClks / 2) @(negedge clk);    // Middle of the start bit
        check("start bit", 0, {31'b0, txd});
        for (i = 0; i < 8; i++)
        begin
            repeat (bitClks) @(negedge clk);
            data[i] = txd;
        end
        repeat (bitClks) @(negedge clk);
        check("stop bit", 1, {31'b0, txd});
    endtask

    task automatic runTest(input string op, input logic [31:0] value);
        logic [31:0] rdata;
        logic [31:0] err;
        logic [7:0]  got;
        int          i;
        case (op)
            "reset":
            begin
                expectStatus(0);
                apbRead(`UART_ADDR_CTRL, rdata, err);
                check("divisor", `UART_DIV_RESET, rdata);
            end
            "div":
            begin
                apbWrite(`UART_ADDR_CTRL, value, err);
                check("divisor write error", 0, err);
                apbRead(`UART_ADDR_CTRL, rdata, err);
                check("divisor", value, rdata);
                nextCycles(2 * curDiv + 2);    // Old period runs out before the reload
                curDiv = int'(value);
            end
            "rx", "ferr":
            begin
                sendSerial(value[7:0], (op == "ferr") ? modeBadStop : modeClean);
                waitRxValid();
                expectStatus((op == "ferr") ? 32'h3 : 32'h1);
                readData(value[7:0]);
            end
            "glitch":
            begin
                sendSerial(8'h00, modeGlitch);
                nextCycles(12 * bitClks);
                expectStatus(0);
            end
            "ovr":
            begin
                for (i = 0; i < `UART_FIFO_DEPTH + 2; i++)
                    sendSerial(value[7:0] + 8'(i), modeClean);
                nextCycles(bitClks);    // Last dropped byte has left the receiver
                expectStatus(32'h5);
                for (i = 0; i < `UART_FIFO_DEPTH; i++)
                    readData(value[7:0] + 8'(i));
                expectStatus(0);
            end
            "tx":
            begin
                apbWrite(`UART_ADDR_DATA, value, err);
                check("first write error", 0, err);
                expectStatus(32'h8);
                apbWrite(`UART_ADDR_DATA, ~value, err);
                check("busy write error", 1, err);
                captureTx(got);
                check("txd byte", value[7:0], {24'h0, got});
                for (i = 0; i < 10 * bitClks; i++)
                begin
                    @(negedge clk);
                    check("txd idle", 1, {31'b0, txd});
                end
                expectStatus(0);
            end
            "empty":
            begin
                apbRead(`UART_ADDR_DATA, rdata, err);
                check("empty read data", 0, rdata);
                check("empty read error", 1, err);
            end
            "unmapped":
            begin
                apbRead(value[7:0], rdata, err);
                check("unmapped read error", 1, err);
                apbWrite(value[7:0], 32'h0, err);
                check("unmapped write error", 1, err);
            end
            default:
                abortRun($sformatf("Unknown operation %s in test %s", op, testName));
        endcase
    endtask

    initial
    begin
        repeat (3000000) @(posedge clk);
        abortRun("Simulation ran too long without finishing");
    end

    initial
    begin
        int          fd;
        int          n;
        int          testCount;
        string       line;
        string       op;
        string       name;
        logic [31:0] value;
        clk       = 1'b0;
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        rxd       = 1'b1;
        curDiv    = `UART_DIV_RESET;
        testName  = "setup";
        testCount = 0;
        void'($urandom(32'h4591));
        nextCycles(10);
        rst = 1'b0;
        fd  = $fopen("verif/uartTests.txt", "r");
        if (fd == 0)
            abortRun("Cannot open the test file verif/uartTests.txt");
        while ($fgets(line, fd) != 0)
        begin
            n = $sscanf(line, "%s %s %h", op, name, value);
            if (n == 3 && op.substr(0, 0) != "#")
            begin
                testName = name;
                runTest(op, value);
                testCount++;
            end
        end
        $fclose(fd);
        if (testCount == 0)
            abortRun("No tests were read from the test file");
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end
endmodule

`default_nettype wire

//--- verilog/uartTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartDefs.svh"

module uartTop (
    input  wire         clk,
    input  wire         rst,
    input  wire [7:0]   paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire [31:0]  pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    input  wire         rxd,
    output logic        txd
);
    logic                   tick;
    logic                   overrun;
    logic                   txBusy;
    logic                   txStart;
    logic [7:0]             txData;
    logic [`UART_DIV_W-1:0] divisor;

    uartByteIf rxStream ();    // Receiver into FIFO
    uartByteIf fifoStream ();  // FIFO head to the register block

    baudTickGen u_baud (
        .clk     (clk),
        .rst     (rst),
        .divisor (divisor),
        .tick    (tick)
    );

    uartRx u_rx (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .rxd     (rxd),
        .outByte (rxStream.source),
        .overrun (overrun)
    );

    rxFifo #(
        .depth (`UART_FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .inByte  (rxStream.sink),
        .outByte (fifoStream.source)
    );

    uartTx u_tx (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .txStart (txStart),
        .txData  (txData),
        .txd     (txd),
        .txBusy  (txBusy)
    );

    uartApbRegs u_regs (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .rxIn    (fifoStream.sink),
        .overrun (overrun),
        .txBusy  (txBusy),
        .txStart (txStart),
        .txData  (txData),
        .divisor (divisor)
    );
endmodule

`default_nettype wire

//--- verilog/uartApbRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartDefs.svh"

module uartApbRegs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [7:0]              paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire [31:0]             pwdata,
    output logic [31:0]            prdata,
    output logic                   pslverr,
    uartByteIf.sink                rxIn,
    input  wire                    overrun,
    input  wire                    txBusy,
    output logic                   txStart,
    output logic [7:0]             txData,
    output logic [`UART_DIV_W-1:0] divisor
);
    import uartPkg::*;

    regSel_e sel;
    logic    readAcc;
    logic    writeAcc;
    logic    statusRead;
    logic    overrunFlag;

    // Every access completes in its access phase
    assign readAcc    = psel & penable & ~pwrite;
    assign writeAcc   = psel & penable & pwrite;
    assign statusRead = readAcc && (sel == regStatus);

    always_comb
    begin
        case (paddr)
            `UART_ADDR_DATA:   sel = regData;
            `UART_ADDR_STATUS: sel = regStatus;
            `UART_ADDR_CTRL:   sel = regCtrl;
            default:           sel = regNone;
        endcase
    end

    always_comb
    begin
        prdata  = '0;
        pslverr = 1'b0;
        if (psel && penable)
        begin
            case (sel)
                regData:
                    if (pwrite)
                        pslverr = txBusy;    // Write dropped while a frame is out
                    else if (rxIn.valid)
                        prdata = {24'h0, rxIn.data};
                    else
                        pslverr = 1'b1;
                regStatus:
                    if (!pwrite)
                        prdata = {28'h0, txBusy, overrunFlag, rxIn.valid & rxIn.frameError,
                                  rxIn.valid};
                regCtrl:
                    if (!pwrite)
                        prdata = 32'(divisor);
                default:
                    pslverr = 1'b1;
            endcase
        end
    end

    assign rxIn.ready = readAcc && (sel == regData);
    assign txStart    = writeAcc && (sel == regData) && !txBusy;
    assign txData     = pwdata[7:0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            overrunFlag <= 1'b0;
            divisor     <= `UART_DIV_W'(`UART_DIV_RESET);
        end
        else
        begin
            // A new overrun in the same cycle survives the clearing read
            overrunFlag <= overrun | (overrunFlag & ~statusRead);
            if (writeAcc && sel == regCtrl)
                divisor <= pwdata[`UART_DIV_W-1:0];
        end
    end
endmodule

`default_nettype wire

//--- verilog/rxFifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartDefs.svh"

module rxFifo #(
    parameter int depth = `UART_FIFO_DEPTH
) (
    input  wire       clk,
    input  wire       rst,
    uartByteIf.sink   inByte,
    uartByteIf.source outByte
);
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    logic [8:0]      mem [depth];    // Frame error flag above the data byte
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            push;
    logic            pop;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign inByte.ready  = (count != cntW'(depth));
    assign outByte.valid = (count != '0);
    assign outByte.data       = mem[rdPtr][7:0];
    assign outByte.frameError = mem[rdPtr][8];

    assign push = inByte.valid & inByte.ready;
    assign pop  = outByte.valid & outByte.ready;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wrPtr] <= {inByte.frameError, inByte.data};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= nextPtr(wrPtr);
            if (pop)
                rdPtr <= nextPtr(rdPtr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end
endmodule

`default_nettype wire

//--- verilog/uartTx.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartDefs.svh"

module uartTx (
    input  wire       clk,
    input  wire       rst,
    input  wire       tick,
    input  wire       txStart,
    input  wire [7:0] txData,
    output logic      txd,
    output logic      txBusy
);
    import uartPkg::*;

    localparam int sampleW = $clog2(`UART_OVERSAMPLE);

    txState_e           state;
    logic               pending;    // Byte latched and waiting for the next tick
    logic [sampleW-1:0] sampleCnt;
    logic [2:0]         bitCnt;
    logic [7:0]         shiftReg;
    logic               lastSample;
    logic               load;

    assign lastSample = (sampleCnt == sampleW'(`UART_OVERSAMPLE - 1));
    assign load       = txStart && !txBusy;
    assign txBusy     = pending | (state != txIdle);

    // The ports txStart and txData hide the state literals, so those states are named through the package
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= txIdle;
            pending   <= 1'b0;
            sampleCnt <= '0;
            bitCnt    <= '0;
            txd       <= 1'b1;
        end
        else
        begin
            if (load)
                pending <= 1'b1;
            if (tick && state == txIdle)
            begin
                if (pending)
                begin
                    pending   <= 1'b0;
                    state     <= uartPkg::txStart;
                    sampleCnt <= '0;
                    txd       <= 1'b0;
                end
            end
            else if (tick && !lastSample)
                sampleCnt <= sampleCnt + 1'b1;
            else if (tick)
            begin
                sampleCnt <= '0;
                case (state)
                    uartPkg::txStart:
                    begin
                        state  <= uartPkg::txData;
                        bitCnt <= '0;
                        txd    <= shiftReg[0];
                    end
                    uartPkg::txData:
                        if (bitCnt == 3'd7)
                        begin
                            state <= txStop;
                            txd   <= 1'b1;
                        end
                        else
                        begin
                            bitCnt <= bitCnt + 1'b1;
                            txd    <= shiftReg[1];
                        end
                    default:
                        state <= txIdle;    // End of stop bit
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            shiftReg <= txData;
        else if (tick && lastSample && state == uartPkg::txData)
            shiftReg <= shiftReg >> 1;
    end
endmodule

`default_nettype wire

//--- verilog/uartRx.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartDefs.svh"

module uartRx (
    input  wire       clk,
    input  wire       rst,
    input  wire       tick,
    input  wire       rxd,
    uartByteIf.source outByte,
    output logic      overrun
);
    import uartPkg::*;

    localparam int sampleW = $clog2(`UART_OVERSAMPLE);

    rxState_e           state;
    logic [1:0]         rxdSync;
    logic               rxBit;
    logic [sampleW-1:0] sampleCnt;
    logic [sampleW:0]   zeroCnt;
    logic [sampleW:0]   oneCnt;
    logic [sampleW:0]   zeroNext;
    logic [sampleW:0]   oneNext;
    logic               majority;
    logic               lastSample;
    logic               bitDone;
    logic [2:0]         bitCnt;
    logic [7:0]         shiftReg;
    logic               validReg;
    logic [7:0]         dataReg;
    logic               frameErrReg;

    assign rxBit = rxdSync[1];

    // Counts include the sample taken on this tick
    assign zeroNext   = zeroCnt + {{sampleW{1'b0}}, ~rxBit};
    assign oneNext    = oneCnt + {{sampleW{1'b0}}, rxBit};
    assign majority   = (oneNext >= zeroNext);    // A tie reads as 1
    assign lastSample = (sampleCnt == sampleW'(`UART_OVERSAMPLE - 1));
    assign bitDone    = tick && lastSample && (state != rxIdle);

    assign outByte.valid      = validReg;
    assign outByte.data       = dataReg;
    assign outByte.frameError = frameErrReg;
    assign overrun            = validReg & ~outByte.ready;    // Byte offered only once

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rxdSync   <= 2'b11;
            state     <= rxIdle;
            sampleCnt <= '0;
            zeroCnt   <= '0;
            oneCnt    <= '0;
            bitCnt    <= '0;
            validReg  <= 1'b0;
        end
        else
        begin
            rxdSync  <= {rxdSync[0], rxd};
            validReg <= 1'b0;
            if (tick && state == rxIdle)
            begin
                if (!rxBit)
                begin
                    // This low sample is the first of the start bit window
                    state     <= rxStart;
                    sampleCnt <= sampleW'(1);
                    zeroCnt   <= (sampleW + 1)'(1);
                    oneCnt    <= '0;
                end
            end
            else if (tick && !lastSample)
            begin
                sampleCnt <= sampleCnt + 1'b1;
                zeroCnt   <= zeroNext;
                oneCnt    <= oneNext;
            end
            else if (bitDone)
            begin
                sampleCnt <= '0;
                zeroCnt   <= '0;
                oneCnt    <= '0;
                case (state)
                    rxStart:
                    begin
                        state  <= majority ? rxIdle : rxData;    // High majority is a glitch
                        bitCnt <= '0;
                    end
                    rxData:
                    begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7)
                            state <= rxStop;
                    end
                    rxStop:
                    begin
                        validReg <= 1'b1;
                        state    <= rxIdle;
                    end
                    default:
                        state <= rxIdle;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (bitDone && state == rxData)
            shiftReg <= {majority, shiftReg[7:1]};    // LSB arrives first
        if (bitDone && state == rxStop)
        begin
            dataReg     <= shiftReg;
            frameErrReg <= ~majority;
        end
    end
endmodule

`default_nettype wire

//--- verilog/baudTickGen.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartDefs.svh"

module baudTickGen (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`UART_DIV_W-1:0]  divisor,
    output logic                   tick
);
    logic [`UART_DIV_W-1:0] count;
    logic [`UART_DIV_W-1:0] activeDiv;    // Divisor sampled at the last reload
    logic [`UART_DIV_W-1:0] lastCount;

    assign lastCount = activeDiv - 1'b1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count     <= '0;
            activeDiv <= `UART_DIV_W'(`UART_DIV_RESET);
            tick      <= 1'b0;
        end
        else if (count == lastCount)
        begin
            count     <= '0;
            activeDiv <= divisor;
            tick      <= 1'b1;
        end
        else
        begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end
endmodule

`default_nettype wire

//--- verilog/uartByteIf.sv
`timescale 1ns/1ps
`default_nettype none

interface uartByteIf;
    logic       valid;
    logic       ready;
    logic [7:0] data;
    logic       frameError;    // Stop bit of this byte was sampled low

    modport source (
        output valid,
        output data,
        output frameError,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  frameError,
        output ready
    );
endinterface

`default_nettype wire

//--- verilog/uartPkg.sv
`default_nettype none

package uartPkg;

    typedef enum logic [1:0] {
        rxIdle,
        rxStart,
        rxData,
        rxStop
    } rxState_e;

    typedef enum logic [1:0] {
        txIdle,
        txStart,
        txData,
        txStop
    } txState_e;

    typedef enum logic [1:0] {
        regData,
        regStatus,
        regCtrl,
        regNone
    } regSel_e;

endpackage

`default_nettype wire

//--- verilog/uartDefs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Serial timing
`define UART_OVERSAMPLE 8
`define UART_DIV_W      16
`define UART_DIV_RESET  16

// Receive buffering
`define UART_FIFO_DEPTH 8

// APB register map in bytes
`define UART_ADDR_DATA   8'h00
`define UART_ADDR_STATUS 8'h04
`define UART_ADDR_CTRL   8'h08

`endif
